//--- rtl/tank_pkg.sv
package tank_pkg;

  localparam int POS_WIDTH     = 12;
  localparam int POS_FRAC_BITS = 4;  // 8.4 fixed point
  localparam int BITMAP_COUNT  = 5;

  typedef enum logic [2:0] {
    WAIT_VSTART = 3'd0,
    WAIT_LOAD   = 3'd1,
    LOAD1_SETUP = 3'd2,
    LOAD1_FETCH = 3'd3,
    LOAD2_SETUP = 3'd4,
    LOAD2_FETCH = 3'd5,
    WAIT_HSTART = 3'd6,
    DRAW        = 3'd7
  } render_state_t;

  typedef enum logic [1:0] {
    STEER_HOLD  = 2'd0,
    STEER_LEFT  = 2'd1,
    STEER_RIGHT = 2'd2
  } steer_op_t;

  // coarse sine from one quarter wave folded four ways
  function automatic logic signed [7:0] sin_16x4(input logic [3:0] angle);
    logic signed [7:0] y;
    case (angle[1:0])
      2'd0:    y = 8'sd0;
      2'd1:    y = 8'sd3;
      2'd2:    y = 8'sd5;
      default: y = 8'sd6;
    endcase
    case (angle[3:2])
      2'd0:    return y;
      2'd1:    return 8'sd7 - y;
      2'd2:    return -y;
      default: return y - 8'sd7;
    endcase
  endfunction

endpackage

//--- rtl/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
  parameter int H_DISPLAY    = 256,
  parameter int H_TOTAL      = 320,
  parameter int H_SYNC_START = 280,
  parameter int H_SYNC_END   = 300,
  parameter int V_DISPLAY    = 240,
  parameter int V_TOTAL      = 262,
  parameter int V_SYNC_START = 245,
  parameter int V_SYNC_END   = 248
) (
  input  logic       clk,
  input  logic       reset,
  output logic [8:0] hpos,
  output logic [8:0] vpos,
  output logic       hsync,
  output logic       vsync,
  output logic       display_on,
  output logic       line_tick,
  output logic       frame_tick
);

  localparam logic [8:0] H_DISP  = 9'(H_DISPLAY);
  localparam logic [8:0] H_LAST  = 9'(H_TOTAL - 1);
  localparam logic [8:0] HS_ON   = 9'(H_SYNC_START);
  localparam logic [8:0] HS_OFF  = 9'(H_SYNC_END);
  localparam logic [8:0] V_DISP  = 9'(V_DISPLAY);
  localparam logic [8:0] V_LAST  = 9'(V_TOTAL - 1);
  localparam logic [8:0] VS_ON   = 9'(V_SYNC_START);
  localparam logic [8:0] VS_OFF  = 9'(V_SYNC_END);

  logic [8:0] hpos_next;
  logic [8:0] vpos_next;

  // ticks mark the last cycle of a line / frame
  assign hpos_next = line_tick ? 9'd0 : hpos + 9'd1;
  assign vpos_next = frame_tick ? 9'd0 : (line_tick ? vpos + 9'd1 : vpos);

  // levels are registered from the next count so they line up with hpos/vpos
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hpos       <= 9'd0;
      vpos       <= 9'd0;
      hsync      <= 1'b0;
      vsync      <= 1'b0;
      line_tick  <= 1'b0;
      frame_tick <= 1'b0;
    end else begin
      hpos       <= hpos_next;
      vpos       <= vpos_next;
      hsync      <= (hpos_next >= HS_ON) && (hpos_next < HS_OFF);
      vsync      <= (vpos_next >= VS_ON) && (vpos_next < VS_OFF);
      line_tick  <= hpos_next == H_LAST;
      frame_tick <= (hpos_next == H_LAST) && (vpos_next == V_LAST);
    end
  end

  assign display_on = (hpos < H_DISP) && (vpos < V_DISP);

endmodule

//--- rtl/tank_bitmap.sv
`timescale 1ns/1ps

module tank_bitmap (
  input  logic [7:0] addr,
  output logic [7:0] bits
);

  import tank_pkg::*;

  logic [15:0] rom [BITMAP_COUNT * 16];  // 16 rows per bitmap
  logic [15:0] word;

  initial begin
    $readmemh("rtl/tank_bitmap.mem", rom);
  end

  assign word = rom[addr[7:1]];
  assign bits = addr[0] ? word[15:8] : word[7:0];  // odd address = high byte

endmodule

//--- rtl/steering_decode.sv
`timescale 1ns/1ps

module steering_decode #(
  parameter int INITIAL_ROT = 0
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       frame_tick,
  input  logic       switch_left,
  input  logic       switch_right,
  input  logic       switch_up,
  output logic [3:0] rotation,
  output logic [3:0] speed,
  output logic [2:0] bitmap_num,
  output logic       hmirror,
  output logic       vmirror
);

  import tank_pkg::*;

  logic      frame_cnt;  // steering on odd frames only
  steer_op_t op;

  always_comb begin
    op = STEER_HOLD;
    if (frame_cnt) begin
      if (switch_left)
        op = STEER_LEFT;
      else if (switch_right)
        op = STEER_RIGHT;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      frame_cnt <= 1'b0;
      rotation  <= 4'(INITIAL_ROT);
      speed     <= 4'd0;
    end else if (frame_tick) begin
      frame_cnt <= ~frame_cnt;
      case (op)
        STEER_LEFT:  rotation <= rotation - 4'd1;
        STEER_RIGHT: rotation <= rotation + 4'd1;
        default:     rotation <= rotation;
      endcase
      if (frame_cnt) begin
        if (!switch_up)
          speed <= 4'd0;
        else if (speed != 4'd15)
          speed <= speed + 4'd1;
      end
    end
  end

  // four quadrants share five bitmaps via mirroring
  always_comb begin
    case (rotation[3:2])
      2'd0: begin
        bitmap_num = {1'b0, rotation[1:0]};
        hmirror    = 1'b0;
        vmirror    = 1'b0;
      end
      2'd1: begin
        bitmap_num = -rotation[2:0];
        hmirror    = 1'b0;
        vmirror    = 1'b1;
      end
      2'd2: begin
        bitmap_num = {1'b0, rotation[1:0]};
        hmirror    = 1'b1;
        vmirror    = 1'b1;
      end
      default: begin
        bitmap_num = -rotation[2:0];
        hmirror    = 1'b1;
        vmirror    = 1'b0;
      end
    endcase
  end

endmodule

//--- rtl/tank_motion.sv
`timescale 1ns/1ps

module tank_motion #(
  parameter int INITIAL_X = 128,
  parameter int INITIAL_Y = 120
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       line_tick,
  input  logic [8:0] vpos,
  input  logic [3:0] rotation,
  input  logic [3:0] speed,
  input  logic       collision,
  output logic [7:0] tank_x,
  output logic [7:0] tank_y
);

  import tank_pkg::*;

  localparam logic [POS_WIDTH-1:0] X_RESET = POS_WIDTH'(INITIAL_X << POS_FRAC_BITS);
  localparam logic [POS_WIDTH-1:0] Y_RESET = POS_WIDTH'(INITIAL_Y << POS_FRAC_BITS);

  logic [POS_WIDTH-1:0] x_fixed;
  logic [POS_WIDTH-1:0] y_fixed;
  logic                 bounce;
  logic                 moving;
  logic signed [7:0]    step_x;
  logic signed [7:0]    step_y;

  assign bounce = collision && vpos[1];  // pushback backwards
  assign moving = bounce || (vpos < {5'd0, speed});
  assign step_x = sin_16x4(bounce ? rotation + 4'd8 : rotation);
  assign step_y = sin_16x4(bounce ? rotation + 4'd12 : rotation + 4'd4);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x_fixed <= X_RESET;
      y_fixed <= Y_RESET;
    end else if (line_tick) begin
      if (moving) begin
        if (vpos[0])  // odd lines move x, even lines move y
          x_fixed <= x_fixed + {{(POS_WIDTH - 8){step_x[7]}}, step_x};
        else
          y_fixed <= y_fixed - {{(POS_WIDTH - 8){step_y[7]}}, step_y};
      end
    end
  end

  assign tank_x = x_fixed[POS_WIDTH-1:POS_FRAC_BITS];
  assign tank_y = y_fixed[POS_WIDTH-1:POS_FRAC_BITS];

endmodule

//--- rtl/sprite_renderer.sv
`timescale 1ns/1ps

module sprite_renderer #(
  parameter int V_TOTAL = 262
) (
  input  logic       clk,
  input  logic       reset,
  input  logic [8:0] hpos,
  input  logic [8:0] vpos,
  input  logic       line_tick,
  input  logic       display_on,
  input  logic [7:0] tank_x,
  input  logic [7:0] tank_y,
  input  logic [2:0] bitmap_num,
  input  logic       hmirror,
  input  logic       vmirror,
  input  logic [7:0] rom_bits,
  output logic [7:0] rom_addr,
  output logic [2:0] rgb,
  output logic       collision
);

  import tank_pkg::*;

  localparam logic [8:0] V_LAST = 9'(V_TOTAL - 1);

  render_state_t state;
  logic [3:0]    ycount;
  logic [3:0]    xcount;
  logic [3:0]    row;
  logic [3:0]    col;
  logic [4:0]    row_byte;
  logic [15:0]   outbits;
  logic          gfx;
  logic          vstart;
  logic          hstart;
  logic          playfield;
  logic          hit;

  assign vstart    = (hpos == 9'd0) && (vpos == {1'b0, tank_y});
  assign hstart    = hpos == {1'b0, tank_x};
  assign row       = vmirror ? ~ycount : ycount;
  assign col       = hmirror ? ~xcount : xcount;
  assign rom_addr  = {bitmap_num, row_byte};
  assign playfield = hpos[5] && vpos[5];  // checkerboard
  assign hit       = display_on && gfx && playfield;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state  <= WAIT_VSTART;
      xcount <= 4'd0;
      ycount <= 4'd0;
      gfx    <= 1'b0;
    end else begin
      case (state)
        WAIT_VSTART: begin
          ycount <= 4'd0;
          gfx    <= 1'b0;
          if (vstart)
            state <= WAIT_LOAD;
        end
        WAIT_LOAD: begin
          xcount <= 4'd0;
          gfx    <= 1'b0;
          if (line_tick)
            state <= LOAD1_SETUP;
        end
        LOAD1_SETUP: state <= LOAD1_FETCH;
        LOAD1_FETCH: state <= LOAD2_SETUP;
        LOAD2_SETUP: state <= LOAD2_FETCH;
        LOAD2_FETCH: state <= WAIT_HSTART;
        WAIT_HSTART: begin
          if (hstart)
            state <= DRAW;
        end
        DRAW: begin
          gfx    <= outbits[col];
          xcount <= xcount + 4'd1;
          if (xcount == 4'd15) begin
            ycount <= ycount + 4'd1;
            state  <= (ycount == 4'd15) ? WAIT_VSTART : WAIT_LOAD;
          end
        end
      endcase
    end
  end

  // row fetch with the low byte first
  always_ff @(posedge clk) begin
    case (state)
      LOAD1_SETUP: row_byte <= {row, 1'b0};
      LOAD1_FETCH: outbits[7:0] <= rom_bits;
      LOAD2_SETUP: row_byte <= {row, 1'b1};
      LOAD2_FETCH: outbits[15:8] <= rom_bits;
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      collision <= 1'b0;
    else if (line_tick && (vpos == V_LAST))  // frame end
      collision <= 1'b0;
    else if (hit)
      collision <= 1'b1;
  end

  assign rgb = {display_on && (gfx || playfield), display_on && gfx, display_on && gfx};

endmodule

//--- rtl/tank_top.sv
`timescale 1ns/1ps

module tank_top #(
  parameter int H_DISPLAY    = 256,
  parameter int H_TOTAL      = 320,
  parameter int H_SYNC_START = 280,
  parameter int H_SYNC_END   = 300,
  parameter int V_DISPLAY    = 240,
  parameter int V_TOTAL      = 262,
  parameter int V_SYNC_START = 245,
  parameter int V_SYNC_END   = 248,
  parameter int INITIAL_X    = 128,
  parameter int INITIAL_Y    = 120,
  parameter int INITIAL_ROT  = 0
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       switch_left,
  input  logic       switch_right,
  input  logic       switch_up,
  output logic       hsync,
  output logic       vsync,
  output logic [2:0] rgb
);

  logic [8:0] hpos;
  logic [8:0] vpos;
  logic       display_on;
  logic       line_tick;
  logic       frame_tick;
  logic [3:0] rotation;
  logic [3:0] speed;
  logic [2:0] bitmap_num;
  logic       hmirror;
  logic       vmirror;
  logic [7:0] tank_x;
  logic [7:0] tank_y;
  logic [7:0] rom_addr;
  logic [7:0] rom_bits;
  logic       collision;

  video_timing #(
    .H_DISPLAY(H_DISPLAY), .H_TOTAL(H_TOTAL),
    .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
    .V_DISPLAY(V_DISPLAY), .V_TOTAL(V_TOTAL),
    .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
  ) video_timing_inst (
    .clk(clk), .reset(reset), .hpos(hpos), .vpos(vpos),
    .hsync(hsync), .vsync(vsync), .display_on(display_on),
    .line_tick(line_tick), .frame_tick(frame_tick)
  );

  tank_bitmap tank_bitmap_inst (
    .addr(rom_addr), .bits(rom_bits)
  );

  steering_decode #(.INITIAL_ROT(INITIAL_ROT)) steering_decode_inst (
    .clk(clk), .reset(reset), .frame_tick(frame_tick),
    .switch_left(switch_left), .switch_right(switch_right), .switch_up(switch_up),
    .rotation(rotation), .speed(speed), .bitmap_num(bitmap_num),
    .hmirror(hmirror), .vmirror(vmirror)
  );

  tank_motion #(.INITIAL_X(INITIAL_X), .INITIAL_Y(INITIAL_Y)) tank_motion_inst (
    .clk(clk), .reset(reset), .line_tick(line_tick), .vpos(vpos),
    .rotation(rotation), .speed(speed), .collision(collision),
    .tank_x(tank_x), .tank_y(tank_y)
  );

  sprite_renderer #(.V_TOTAL(V_TOTAL)) sprite_renderer_inst (
    .clk(clk), .reset(reset), .hpos(hpos), .vpos(vpos),
    .line_tick(line_tick), .display_on(display_on),
    .tank_x(tank_x), .tank_y(tank_y), .bitmap_num(bitmap_num),
    .hmirror(hmirror), .vmirror(vmirror), .rom_bits(rom_bits),
    .rom_addr(rom_addr), .rgb(rgb), .collision(collision)
  );

endmodule

//--- verif/tank_assert.sv
`timescale 1ns/1ps

module tank_assert (
  input logic                    clk,
  input logic                    reset,
  input tank_pkg::render_state_t state,
  input logic [3:0]              xcount,
  input logic [2:0]              rgb,
  input logic                    display_on,
  input logic                    gfx,
  input logic                    collision
);

  import tank_pkg::*;

  // a row is always 16 pixels wide
  assert property (@(posedge clk) disable iff (reset)
    (state == DRAW && xcount != 4'd15) |=> state == DRAW)
    else $error("renderer left DRAW before the end of the row");

  assert property (@(posedge clk) disable iff (reset) !display_on |-> rgb == 3'b000)
    else $error("rgb not black during blanking");

  assert property (@(posedge clk) disable iff (reset) $rose(collision) |-> $past(gfx))
    else $error("collision set without a tank pixel");

endmodule

bind sprite_renderer tank_assert tank_assert_inst (
  .clk(clk), .reset(reset), .state(state), .xcount(xcount), .rgb(rgb),
  .display_on(display_on), .gfx(gfx), .collision(collision)
);

//--- verif/tank_tb.sv
`timescale 1ns/1ps

module tank_tb;

  localparam int FRAMES = 12;
  localparam int CYCLE_LIMIT = FRAMES * 320 * 262 + 2000;
  localparam logic [8:0] H_LAST = 9'd319;
  localparam logic [8:0] V_LAST = 9'd261;

  logic clk;
  logic reset;
  logic switch_left;
  logic switch_right;
  logic switch_up;
  logic hsync;
  logic vsync;
  logic [2:0] rgb;

  // reference model registers
  logic [8:0]  m_h;
  logic [8:0]  m_v;
  logic        m_odd;
  logic [3:0]  m_rot;
  logic [3:0]  m_spd;
  logic [11:0] m_x;
  logic [11:0] m_y;
  logic        m_coll;
  logic [2:0]  m_phase;
  logic [3:0]  m_xc;
  logic [3:0]  m_yc;
  logic [15:0] m_word;
  logic        m_gfx;
  logic [15:0] image [80];
  logic [31:0] lfsr;
  int          frames;
  int          cycles = 0;
  int          error_count = 0;

  tank_top tank_top_inst (
    .clk(clk), .reset(reset), .switch_left(switch_left), .switch_right(switch_right),
    .switch_up(switch_up), .hsync(hsync), .vsync(vsync), .rgb(rgb)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b = lfsr[0];
  endtask

  // quarter wave 0,3,5,6 mirrored per quadrant
  function automatic logic signed [7:0] sine_step(input logic [3:0] a);
    logic signed [7:0] base;
    logic signed [7:0] q;
    base = (a[1:0] == 2'd0) ? 8'sd0 : (a[1:0] == 2'd1) ? 8'sd3 : (a[1:0] == 2'd2) ? 8'sd5 : 8'sd6;
    q = a[2] ? 8'sd7 - base : base;
    return a[3] ? -q : q;
  endfunction

  // {bitmap, hmirror, vmirror}
  function automatic logic [4:0] sprite_select(input logic [3:0] rot);
    logic [2:0] bm;
    bm = rot[2] ? 3'(4'd8 - {1'b0, rot[2:0]}) : {1'b0, rot[1:0]};
    return {bm, rot[3], rot[3] ^ rot[2]};
  endfunction

  function automatic logic display_area(input logic [8:0] h, input logic [8:0] v);
    return (h < 9'd256) && (v < 9'd240);
  endfunction

  task automatic compare_signal(input string name, input logic [7:0] actual,
                                input logic [7:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "output mismatch");
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    $readmemh("rtl/tank_bitmap.mem", image);
    lfsr = 32'h629f_9656;
    switch_left = 1'b0;
    switch_right = 1'b0;
    switch_up = 1'b0;
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    wait (frames == FRAMES);
    @(negedge clk);
    if (error_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "errors seen");
    end
  end

  // new switch values once per frame at mid screen
  always @(posedge clk) begin : stimulus
    logic l;
    logic r;
    logic u;
    if (!reset && m_h == H_LAST && m_v == 9'd130) begin
      take_bit(l);
      take_bit(r);
      take_bit(u);
      switch_left  <= (frames >= 2) && l;
      switch_right <= (frames >= 2) && r;
      switch_up    <= (frames >= 2 && frames < 9) || (frames >= 10 && u);  // held then released
    end
  end

  always @(posedge clk or posedge reset) begin : model
    logic              line_t;
    logic              frame_t;
    logic              bounce;
    logic              moving;
    logic              disp;
    logic signed [7:0] sx;
    logic signed [7:0] sy;
    logic [4:0]        sel;
    logic [3:0]        row;
    if (reset) begin
      m_h <= 9'd0;
      m_v <= 9'd0;
      m_odd <= 1'b0;
      m_rot <= 4'd0;
      m_spd <= 4'd0;
      m_x <= 12'(128 << 4);
      m_y <= 12'(120 << 4);
      m_coll <= 1'b0;
      m_phase <= 3'd0;
      m_xc <= 4'd0;
      m_yc <= 4'd0;
      m_word <= 16'd0;
      m_gfx <= 1'b0;
      frames <= 0;
    end else begin
      line_t = m_h == H_LAST;
      frame_t = line_t && (m_v == V_LAST);
      sel = sprite_select(m_rot);
      disp = display_area(m_h, m_v);
      m_h <= line_t ? 9'd0 : m_h + 9'd1;
      if (frame_t)
        m_v <= 9'd0;
      else if (line_t)
        m_v <= m_v + 9'd1;
      if (frame_t) begin
        frames <= frames + 1;
        m_odd <= ~m_odd;
        if (m_odd) begin  // steering frame
          if (switch_left)
            m_rot <= m_rot - 4'd1;
          else if (switch_right)
            m_rot <= m_rot + 4'd1;
          m_spd <= !switch_up ? 4'd0 : (m_spd == 4'd15 ? 4'd15 : m_spd + 4'd1);
        end
      end
      bounce = m_coll && m_v[1];
      moving = bounce || (m_v < {5'd0, m_spd});
      sx = sine_step(bounce ? m_rot + 4'd8 : m_rot);
      sy = sine_step(bounce ? m_rot + 4'd12 : m_rot + 4'd4);
      if (line_t && moving) begin
        if (m_v[0])
          m_x <= m_x + {{4{sx[7]}}, sx};
        else
          m_y <= m_y - {{4{sy[7]}}, sy};
      end
      if (frame_t)
        m_coll <= 1'b0;
      else if (disp && m_gfx && m_h[5] && m_v[5])
        m_coll <= 1'b1;
      row = sel[0] ? ~m_yc : m_yc;
      case (m_phase)
        3'd0: begin
          m_yc <= 4'd0;
          m_gfx <= 1'b0;
          if (m_h == 9'd0 && m_v == {1'b0, m_y[11:4]})
            m_phase <= 3'd1;
        end
        3'd1: begin
          m_xc <= 4'd0;
          m_gfx <= 1'b0;
          if (line_t)
            m_phase <= 3'd2;
        end
        3'd3: begin
          m_word <= image[{sel[4:2], row}];
          m_phase <= 3'd4;
        end
        3'd6: begin
          if (m_h == {1'b0, m_x[11:4]})
            m_phase <= 3'd7;
        end
        3'd7: begin
          m_gfx <= m_word[sel[1] ? ~m_xc : m_xc];
          m_xc <= m_xc + 4'd1;
          if (m_xc == 4'd15) begin
            m_yc <= m_yc + 4'd1;
            m_phase <= (m_yc == 4'd15) ? 3'd0 : 3'd1;
          end
        end
        default: m_phase <= m_phase + 3'd1;  // fetch cycles
      endcase
    end
  end

  always @(negedge clk) begin : compare
    logic disp;
    logic pf;
    if (!reset) begin
      disp = display_area(m_h, m_v);
      pf = m_h[5] && m_v[5];
      compare_signal("hsync", {7'b0, hsync}, {7'b0, (m_h >= 9'd280) && (m_h < 9'd300)});
      compare_signal("vsync", {7'b0, vsync}, {7'b0, (m_v >= 9'd245) && (m_v < 9'd248)});
      compare_signal("rgb", {5'b0, rgb},
                     {5'b0, disp && (m_gfx || pf), disp && m_gfx, disp && m_gfx});
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: the frames did not complete within the cycle limit");
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

endmodule

//--- rtl/tank_bitmap.mem
// one 16-bit sprite row per line, bit 0 is the leftmost pixel; bitmaps 0 to 4, 16 rows each
0000
0180
0180
0180
0180
3dbc
3ffc
3ffc
3e7c
3e7c
3ffc
3ffc
3ffc
3c3c
3c3c
0000
0000
0300
0300
0600
0600
3dbc
3ffc
1ffe
1e7e
3e7c
3ffc
7ff8
7ff0
3c30
0c00
0000
0000
0000
0c00
0600
0370
1ffc
1ffe
3fff
1e7e
3e7c
7ffc
3ff8
0ff0
03c0
0000
0000
0000
0000
0000
0700
1fc0
0ff0
07fc
3ffe
3fff
1fff
1ffe
07f8
03f0
01e0
00c0
0000
0000
0000
0000
0000
0ff0
0ff0
0ff0
0ff0
fffe
fffe
0ff0
0ff0
0ff0
0ff0
0000
0000

//--- files.f
rtl/tank_pkg.sv
rtl/video_timing.sv
rtl/tank_bitmap.sv
rtl/steering_decode.sv
rtl/tank_motion.sv
rtl/sprite_renderer.sv
rtl/tank_top.sv
verif/tank_assert.sv
verif/tank_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tank_tb
FILELIST  ?= files.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
